//--- design/icache_pkg.sv
/*
  Instruction cache shared definitions
  Address and instruction widths, block layout and the tag entry format
*/
package icache_pkg;

  localparam int ADDR_WIDTH     = 32;
  localparam int INSTR_WIDTH    = 32;
  localparam int BLOCK_WORDS    = 4;
  localparam int OFFSET_WIDTH   = 4;
  localparam int BLK_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

  // One whole cache block, word 0 in the low bits
  typedef logic [BLOCK_WORDS*INSTR_WIDTH-1:0] block_t;

  // Full block address is kept so the entry is independent of the set count
  typedef struct packed {
    logic                      valid;
    logic [BLK_ADDR_WIDTH-1:0] blk_addr;
  } tag_entry_t;

endpackage

//--- design/icache_sram.sv
/*
  Single-port synchronous RAM
  Read data appears one cycle after a read and holds until the next read
*/
module icache_sram #(
  parameter type payload_t = logic,
  parameter int  els_p     = 16,
  localparam int addr_width_lp = $clog2(els_p)
) (
  input  logic                     clk_i,
  input  logic                     v_i,
  input  logic                     w_i,
  input  logic [addr_width_lp-1:0] addr_i,
  input  payload_t                 data_i,
  output payload_t                 data_o
);

  payload_t mem_r [els_p];

  // Output register only moves on a read, writes leave it alone
  always_ff @(posedge clk_i)
  begin
    if (v_i & w_i)
    begin
      mem_r[addr_i] <= data_i;
    end
    else if (v_i)
    begin
      data_o <= mem_r[addr_i];
    end
  end

endmodule

//--- design/icache_lookup.sv
/*
  Instruction cache lookup pipeline
  Decode issues the RAM read, TL compares tags, TV holds the result,
  selects the instruction word and picks the replacement way
*/
module icache_lookup #(
  parameter int  sets_p  = 16,
  parameter int  assoc_p = 4,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int lg_assoc_lp    = $clog2(assoc_p)
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0]     fetch_addr_i,
  input  logic                                  fetch_v_i,
  input  logic                                  yumi_i,
  input  logic                                  flush_i,
  input  logic                                  state_ready_i,
  input  logic                                  state_recover_i,
  input  icache_pkg::tag_entry_t [assoc_p-1:0]  tag_rd_i,
  input  icache_pkg::block_t [assoc_p-1:0]      data_rd_i,
  input  logic [lg_assoc_lp-1:0]                lru_way_i,
  output logic                                  fetch_yumi_o,
  output logic [icache_pkg::INSTR_WIDTH-1:0]    data_o,
  output logic                                  data_v_o,
  output logic                                  rd_v_o,
  output logic [index_width_lp-1:0]             rd_index_o,
  output logic                                  req_v_o,
  output logic [icache_pkg::BLK_ADDR_WIDTH-1:0] req_blk_addr_o,
  output logic [lg_assoc_lp-1:0]                victim_way_o,
  output logic                                  hit_v_o,
  output logic [lg_assoc_lp-1:0]                hit_way_o,
  output logic [index_width_lp-1:0]             tv_index_o
);

  localparam int word_sel_lp = $clog2(icache_pkg::BLOCK_WORDS);
  localparam int byte_sel_lp = icache_pkg::OFFSET_WIDTH - word_sel_lp;

  logic                              tl_v_r;
  logic                              tv_v_r;
  logic                              reload_r;
  logic [icache_pkg::ADDR_WIDTH-1:0] tl_addr_r;
  logic [icache_pkg::ADDR_WIDTH-1:0] tv_addr_r;
  logic [assoc_p-1:0]                way_v_tl;
  logic [assoc_p-1:0]                hit_tl;
  logic [assoc_p-1:0]                tv_hit_r;
  logic [assoc_p-1:0]                tv_way_v_r;
  icache_pkg::block_t [assoc_p-1:0]  tv_blocks_r;
  logic                              tl_miss;
  logic                              tl_drain;
  logic                              tv_miss;
  logic                              tv_done;
  logic                              req_hold;
  logic                              invalid_found;
  logic [lg_assoc_lp-1:0]            invalid_way;

  logic [icache_pkg::BLOCK_WORDS-1:0][icache_pkg::INSTR_WIDTH-1:0] hit_words;

  ////////////////////
  // Decode
  ////////////////////

  // A missing fetch in TL or TV blocks new fetches until it is refilled
  assign fetch_yumi_o = state_ready_i & fetch_v_i & ~tv_miss
                      & (~tl_v_r | (tl_drain & ~tl_miss));

  // Recover re-reads the set of the fetch still held in TL
  assign rd_v_o     = fetch_yumi_o | state_recover_i;
  assign rd_index_o = state_recover_i
                    ? tl_addr_r[icache_pkg::OFFSET_WIDTH +: index_width_lp]
                    : fetch_addr_i[icache_pkg::OFFSET_WIDTH +: index_width_lp];

  ////////////////////
  // TL stage
  ////////////////////

  for (genvar i = 0; i < assoc_p; i++)
  begin : g_tag_cmp
    assign way_v_tl[i] = tag_rd_i[i].valid;
    assign hit_tl[i]   = way_v_tl[i]
                       & (tag_rd_i[i].blk_addr
                          == tl_addr_r[icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_WIDTH]);
  end

  assign tl_miss  = tl_v_r & ~|hit_tl;
  assign tl_drain = tl_v_r & (~tv_v_r | tv_done);

  always_ff @(posedge clk_i)
  begin
    if (fetch_yumi_o)
      tl_addr_r <= fetch_addr_i;
  end

  ////////////////////
  // TV stage
  ////////////////////

  assign tv_miss  = tv_v_r & ~|tv_hit_r;
  assign data_v_o = tv_v_r & |tv_hit_r;
  assign tv_done  = data_v_o & yumi_i;

  // No request in the cycle TV reloads after recover
  assign req_v_o  = tv_miss & ~reload_r;
  assign req_hold = req_v_o & state_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tl_v_r   <= 1'b0;
      tv_v_r   <= 1'b0;
      reload_r <= 1'b0;
    end
    else
    begin
      reload_r <= state_recover_i;

      if (fetch_yumi_o)
        tl_v_r <= 1'b1;
      else if (flush_i | tl_drain)
        tl_v_r <= 1'b0;

      // A request already on the memory bus cannot be withdrawn
      if (flush_i & ~req_hold)
        tv_v_r <= 1'b0;
      else if (tl_drain)
        tv_v_r <= 1'b1;
      else if (tv_done)
        tv_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_drain)
      tv_addr_r <= tl_addr_r;
    if (tl_drain | reload_r)
    begin
      tv_hit_r    <= hit_tl;
      tv_way_v_r  <= way_v_tl;
      tv_blocks_r <= data_rd_i;
    end
  end

  // One-hot hit to way number
  always_comb
  begin
    hit_way_o = '0;
    for (int i = 0; i < assoc_p; i++)
    begin
      if (tv_hit_r[i])
        hit_way_o = lg_assoc_lp'(i);
    end
  end

  assign hit_words = tv_blocks_r[hit_way_o];
  assign data_o    = hit_words[tv_addr_r[byte_sel_lp +: word_sel_lp]];

  // Lowest invalid way wins over the LRU way
  always_comb
  begin
    invalid_found = 1'b0;
    invalid_way   = '0;
    for (int i = assoc_p - 1; i >= 0; i--)
    begin
      if (~tv_way_v_r[i])
      begin
        invalid_found = 1'b1;
        invalid_way   = lg_assoc_lp'(i);
      end
    end
  end

  assign victim_way_o   = invalid_found ? invalid_way : lru_way_i;
  assign req_blk_addr_o = tv_addr_r[icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_WIDTH];
  assign tv_index_o     = tv_addr_r[icache_pkg::OFFSET_WIDTH +: index_width_lp];
  assign hit_v_o        = tv_done;

endmodule

//--- design/icache_lru.sv
/*
  Pseudo-tree LRU state
  One tree of assoc_p-1 bits per set, victim encode and hit update
*/
module icache_lru #(
  parameter int  sets_p  = 16,
  parameter int  assoc_p = 4,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int lg_assoc_lp    = $clog2(assoc_p)
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [index_width_lp-1:0] index_i,
  input  logic                      update_i,
  input  logic [lg_assoc_lp-1:0]    hit_way_i,
  output logic [lg_assoc_lp-1:0]    lru_way_o
);

  // Heap order, node k has children 2k+1 and 2k+2
  logic [assoc_p-2:0] bits_r [sets_p];
  logic [assoc_p-2:0] cur_bits;
  logic [assoc_p-2:0] upd_bits;

  assign cur_bits = bits_r[index_i];

  // Follow the bits from the root toward the least recent leaf
  always_comb
  begin
    int node;
    node      = 0;
    lru_way_o = '0;
    for (int lvl = 0; lvl < lg_assoc_lp; lvl++)
    begin
      lru_way_o[lg_assoc_lp-1-lvl] = cur_bits[node];
      node = 2 * node + 1 + int'(cur_bits[node]);
    end
  end

  // Point every node on the hit path away from the hit way
  always_comb
  begin
    int unode;
    unode    = 0;
    upd_bits = cur_bits;
    for (int lvl = 0; lvl < lg_assoc_lp; lvl++)
    begin
      upd_bits[unode] = ~hit_way_i[lg_assoc_lp-1-lvl];
      unode = 2 * unode + 1 + int'(hit_way_i[lg_assoc_lp-1-lvl]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < sets_p; s++)
        bits_r[s] <= '0;
    end
    else if (update_i)
    begin
      bits_r[index_i] <= upd_bits;
    end
  end

endmodule

//--- design/icache_ctrl.sv
/*
  Instruction cache controller
  Tag sweep after reset, ready/miss/recover FSM, block request and fill writes
*/
module icache_ctrl #(
  parameter int  sets_p  = 16,
  parameter int  assoc_p = 4,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int lg_assoc_lp    = $clog2(assoc_p)
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  req_v_i,
  input  logic [icache_pkg::BLK_ADDR_WIDTH-1:0] req_blk_addr_i,
  input  logic [lg_assoc_lp-1:0]                victim_way_i,
  input  logic                                  mem_req_ready_i,
  input  logic                                  fill_v_i,
  input  icache_pkg::block_t                    fill_data_i,
  output logic                                  mem_req_v_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0]     mem_req_addr_o,
  output logic                                  state_ready_o,
  output logic                                  state_recover_o,
  output logic                                  tag_w_o,
  output logic [lg_assoc_lp-1:0]                tag_w_way_o,
  output icache_pkg::tag_entry_t                tag_w_entry_o,
  output logic [assoc_p-1:0]                    data_w_o,
  output logic [index_width_lp-1:0]             data_w_index_o,
  output icache_pkg::block_t                    data_w_block_o
);

  typedef enum logic [1:0] {e_ready, e_miss, e_recover} state_e;

  state_e                                state_r;
  state_e                                state_n;
  logic                                  sweep_r;
  logic [index_width_lp-1:0]             sweep_cnt_r;
  logic [icache_pkg::BLK_ADDR_WIDTH-1:0] miss_blk_r;
  logic [lg_assoc_lp-1:0]                miss_way_r;
  logic                                  fill_w;

  ////////////////////
  // Request and FSM
  ////////////////////

  assign mem_req_v_o    = (state_r == e_ready) & ~sweep_r & req_v_i;
  assign mem_req_addr_o = {req_blk_addr_i, {icache_pkg::OFFSET_WIDTH{1'b0}}};

  always_comb
  begin
    case (state_r)
      e_ready:   state_n = (mem_req_v_o & mem_req_ready_i) ? e_miss : e_ready;
      e_miss:    state_n = fill_v_i ? e_recover : e_miss;
      default:   state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r     <= e_ready;
      sweep_r     <= 1'b1;
      sweep_cnt_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (sweep_r)
      begin
        sweep_cnt_r <= sweep_cnt_r + 1'b1;
        if (sweep_cnt_r == index_width_lp'(sets_p - 1))
          sweep_r <= 1'b0;
      end
    end
  end

  // Miss block and its victim, captured when memory takes the request
  always_ff @(posedge clk_i)
  begin
    if (mem_req_v_o & mem_req_ready_i)
    begin
      miss_blk_r <= req_blk_addr_i;
      miss_way_r <= victim_way_i;
    end
  end

  assign state_ready_o   = (state_r == e_ready) & ~sweep_r;
  assign state_recover_o = (state_r == e_recover);

  ////////////////////
  // RAM writes
  ////////////////////

  assign fill_w = (state_r == e_miss) & fill_v_i;

  // Sweep writes invalid entries, the fill writes a valid one
  assign tag_w_o                = sweep_r | fill_w;
  assign tag_w_way_o            = miss_way_r;
  assign tag_w_entry_o.valid    = ~sweep_r;
  assign tag_w_entry_o.blk_addr = sweep_r ? '0 : miss_blk_r;

  assign data_w_o       = {{(assoc_p - 1){1'b0}}, fill_w} << miss_way_r;
  assign data_w_index_o = sweep_r ? sweep_cnt_r : miss_blk_r[index_width_lp-1:0];
  assign data_w_block_o = fill_data_i;

endmodule

//--- design/icache.sv
/*
  Set-associative instruction cache, three stage pipeline
  Connects the lookup pipeline, controller, LRU and the tag and data RAMs
*/
module icache #(
  parameter int sets_p  = 16,
  parameter int assoc_p = 4
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
  input  logic                              fetch_v_i,
  output logic                              fetch_yumi_o,
  output logic [icache_pkg::INSTR_WIDTH-1:0] data_o,
  output logic                              data_v_o,
  input  logic                              yumi_i,
  output logic                              mem_req_v_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0] mem_req_addr_o,
  input  logic                              mem_req_ready_i,
  input  logic                              fill_v_i,
  input  icache_pkg::block_t                fill_data_i,
  input  logic                              flush_i
);

  localparam int index_width_lp = $clog2(sets_p);
  localparam int lg_assoc_lp    = $clog2(assoc_p);

  // All ways of one set share one tag RAM word
  typedef icache_pkg::tag_entry_t [assoc_p-1:0] tag_set_t;

  logic                                  rd_v;
  logic [index_width_lp-1:0]             rd_index;
  tag_set_t                              tag_rd;
  tag_set_t                              tag_w_data;
  icache_pkg::block_t [assoc_p-1:0]      data_rd;
  logic [lg_assoc_lp-1:0]                lru_way;
  logic                                  req_v;
  logic [icache_pkg::BLK_ADDR_WIDTH-1:0] req_blk_addr;
  logic [lg_assoc_lp-1:0]                victim_way;
  logic                                  hit_v;
  logic [lg_assoc_lp-1:0]                hit_way;
  logic [index_width_lp-1:0]             tv_index;
  logic                                  state_ready;
  logic                                  state_recover;
  logic                                  tag_w;
  logic [lg_assoc_lp-1:0]                tag_w_way;
  icache_pkg::tag_entry_t                tag_w_entry;
  logic [assoc_p-1:0]                    data_w;
  logic [index_width_lp-1:0]             data_w_index;
  icache_pkg::block_t                    data_w_block;

  icache_lookup #(.sets_p(sets_p), .assoc_p(assoc_p)) lookup_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_v_i      (fetch_v_i),
    .yumi_i         (yumi_i),
    .flush_i        (flush_i),
    .state_ready_i  (state_ready),
    .state_recover_i(state_recover),
    .tag_rd_i       (tag_rd),
    .data_rd_i      (data_rd),
    .lru_way_i      (lru_way),
    .fetch_yumi_o   (fetch_yumi_o),
    .data_o         (data_o),
    .data_v_o       (data_v_o),
    .rd_v_o         (rd_v),
    .rd_index_o     (rd_index),
    .req_v_o        (req_v),
    .req_blk_addr_o (req_blk_addr),
    .victim_way_o   (victim_way),
    .hit_v_o        (hit_v),
    .hit_way_o      (hit_way),
    .tv_index_o     (tv_index)
  );

  icache_ctrl #(.sets_p(sets_p), .assoc_p(assoc_p)) ctrl_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_v_i        (req_v),
    .req_blk_addr_i (req_blk_addr),
    .victim_way_i   (victim_way),
    .mem_req_ready_i(mem_req_ready_i),
    .fill_v_i       (fill_v_i),
    .fill_data_i    (fill_data_i),
    .mem_req_v_o    (mem_req_v_o),
    .mem_req_addr_o (mem_req_addr_o),
    .state_ready_o  (state_ready),
    .state_recover_o(state_recover),
    .tag_w_o        (tag_w),
    .tag_w_way_o    (tag_w_way),
    .tag_w_entry_o  (tag_w_entry),
    .data_w_o       (data_w),
    .data_w_index_o (data_w_index),
    .data_w_block_o (data_w_block)
  );

  icache_lru #(.sets_p(sets_p), .assoc_p(assoc_p)) lru_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .index_i  (tv_index),
    .update_i (hit_v),
    .hit_way_i(hit_way),
    .lru_way_o(lru_way)
  );

  ////////////////////
  // Tag RAM
  ////////////////////

  // Other ways keep the entries still held from the read of this set,
  // an invalidating write clears the whole set
  always_comb
  begin
    for (int i = 0; i < assoc_p; i++)
    begin
      if ((tag_w_way == lg_assoc_lp'(i)) | ~tag_w_entry.valid)
        tag_w_data[i] = tag_w_entry;
      else
        tag_w_data[i] = tag_rd[i];
    end
  end

  icache_sram #(.payload_t(tag_set_t), .els_p(sets_p)) tag_ram_i (
    .clk_i (clk_i),
    .v_i   (rd_v | tag_w),
    .w_i   (tag_w),
    .addr_i(tag_w ? data_w_index : rd_index),
    .data_i(tag_w_data),
    .data_o(tag_rd)
  );

  ////////////////////
  // Data RAMs
  ////////////////////

  for (genvar w = 0; w < assoc_p; w++)
  begin : g_data_way
    icache_sram #(.payload_t(icache_pkg::block_t), .els_p(sets_p)) data_ram_i (
      .clk_i (clk_i),
      .v_i   (rd_v | data_w[w]),
      .w_i   (data_w[w]),
      .addr_i(data_w[w] ? data_w_index : rd_index),
      .data_i(data_w_block),
      .data_o(data_rd[w])
    );
  end

endmodule

//--- tb/icache_assertions.sv
/*
  Instruction cache handshake checks
  Bound to the top level, covers the memory request, output hold and reset
*/
module icache_assertions (
  input logic                              clk_i,
  input logic                              reset_i,
  input logic                              data_v_o,
  input logic [icache_pkg::INSTR_WIDTH-1:0] data_o,
  input logic                              yumi_i,
  input logic                              flush_i,
  input logic                              mem_req_v_o,
  input logic [icache_pkg::ADDR_WIDTH-1:0] mem_req_addr_o,
  input logic                              mem_req_ready_i
);

  // Memory request and its address stay put until memory takes them
  mem_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_o && !mem_req_ready_i |=> mem_req_v_o && $stable(mem_req_addr_o))
    else $error("memory request dropped or changed before ready");

  // Word waiting for the consumer holds
  data_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o && !yumi_i && !flush_i |=> data_v_o && $stable(data_o))
    else $error("output word dropped or changed under back-pressure");

  data_idle_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !data_v_o)
    else $error("output valid high right after reset");

endmodule

bind icache icache_assertions assertions_i (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .data_v_o       (data_v_o),
  .data_o         (data_o),
  .yumi_i         (yumi_i),
  .flush_i        (flush_i),
  .mem_req_v_o    (mem_req_v_o),
  .mem_req_addr_o (mem_req_addr_o),
  .mem_req_ready_i(mem_req_ready_i)
);

//--- tb/icache_tb.sv
/*
  Instruction cache testbench
  Drives fetches through the DUT with a block memory model behind it,
  runs the directed tests and prints a result summary
*/
module icache_tb;

  localparam int CLK_PERIOD      = 20;
  localparam int SAMPLE_DELAY    = CLK_PERIOD / 4;
  localparam int RESET_CYCLES    = 10;
  localparam int SWEEP_CYCLES    = 16;
  localparam int REQ_WAIT        = 2;
  localparam int FILL_WAIT       = 3;
  localparam int RANDOM_FETCHES  = 200;
  localparam int DIRECTED_FETCH  = 11;
  localparam int FETCH_CYCLES    = 40;
  localparam int TEST_COUNT      = 5;
  localparam int WATCHDOG_TIME   = (RESET_CYCLES + SWEEP_CYCLES
                                   + (DIRECTED_FETCH + RANDOM_FETCHES) * FETCH_CYCLES)
                                   * CLK_PERIOD;

  logic                                 clk;
  logic                                 reset;
  logic [icache_pkg::ADDR_WIDTH-1:0]    fetch_addr;
  logic                                 fetch_v;
  logic                                 fetch_yumi;
  logic [icache_pkg::INSTR_WIDTH-1:0]   fetch_data;
  logic                                 data_v;
  logic                                 yumi;
  logic                                 mem_req_v;
  logic [icache_pkg::ADDR_WIDTH-1:0]    mem_req_addr;
  logic                                 mem_req_ready;
  logic                                 fill_v;
  icache_pkg::block_t                   fill_data;
  logic                                 flush;

  int          errors;
  int          checks;
  int          req_count;
  logic [31:0] last_req_addr;
  logic [31:0] rand_state;

  icache dut_i (
    .clk_i          (clk),
    .reset_i        (reset),
    .fetch_addr_i   (fetch_addr),
    .fetch_v_i      (fetch_v),
    .fetch_yumi_o   (fetch_yumi),
    .data_o         (fetch_data),
    .data_v_o       (data_v),
    .yumi_i         (yumi),
    .mem_req_v_o    (mem_req_v),
    .mem_req_addr_o (mem_req_addr),
    .mem_req_ready_i(mem_req_ready),
    .fill_v_i       (fill_v),
    .fill_data_i    (fill_data),
    .flush_i        (flush)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Memory contents, each word is its own address with a fixed pattern
  function automatic logic [31:0] model_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
  endfunction

  function automatic icache_pkg::block_t model_block(input logic [31:0] base);
    icache_pkg::block_t blk;
    for (int i = 0; i < icache_pkg::BLOCK_WORDS; i++)
      blk[i*icache_pkg::INSTR_WIDTH +: icache_pkg::INSTR_WIDTH] = model_word(base + 32'(4 * i));
    return blk;
  endfunction

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Block memory, answers each request a few cycles later with one fill
  initial
  begin : memory_model
    logic [31:0] base;
    mem_req_ready = 1'b0;
    fill_v        = 1'b0;
    fill_data     = '0;
    req_count     = 0;
    last_req_addr = '0;
    forever
    begin
      @(negedge clk);
      #(SAMPLE_DELAY);
      if (mem_req_v === 1'b1 && reset === 1'b0)
      begin
        base = mem_req_addr;
        // Counted when first seen so a request is never missed by the fetch
        req_count++;
        last_req_addr = base;
        repeat (REQ_WAIT) @(negedge clk);
        mem_req_ready = 1'b1;
        @(negedge clk);
        mem_req_ready = 1'b0;
        repeat (FILL_WAIT) @(negedge clk);
        fill_data = model_block(base);
        fill_v    = 1'b1;
        @(negedge clk);
        fill_v    = 1'b0;
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    assert (got == exp)
    else
    begin
      errors++;
      $display("ERROR %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("%s: finished with %0d errors", name, errors - start_errors);
  endtask

  // Holds the fetch until the cache takes it, returns on the next falling edge
  task automatic issue_fetch(input logic [31:0] addr);
    @(negedge clk);
    fetch_v    = 1'b1;
    fetch_addr = addr;
    #(SAMPLE_DELAY);
    while (fetch_yumi !== 1'b1)
    begin
      @(negedge clk);
      #(SAMPLE_DELAY);
    end
    @(negedge clk);
    fetch_v = 1'b0;
  endtask

  task automatic fetch_word(input logic [31:0] addr, input int hold,
                            output logic [31:0] word, output int lat, output int reqs);
    int start_reqs;
    start_reqs = req_count;
    issue_fetch(addr);
    lat = 1;
    #(SAMPLE_DELAY);
    while (data_v !== 1'b1)
    begin
      @(negedge clk);
      #(SAMPLE_DELAY);
      lat++;
    end
    word = fetch_data;
    // Consumer stalls for hold cycles before taking the word
    repeat (hold)
    begin
      @(negedge clk);
      #(SAMPLE_DELAY);
      check_value(32'(data_v), 32'd1, "valid under back-pressure");
      check_value(fetch_data, word, "data under back-pressure");
    end
    @(negedge clk);
    yumi = 1'b1;
    @(negedge clk);
    yumi = 1'b0;
    reqs = req_count - start_reqs;
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  // First fetch also waits out the tag sweep
  task automatic cold_miss_test();
    logic [31:0] addr;
    logic [31:0] word;
    int          lat;
    int          reqs;
    int          start_errors;
    start_errors = errors;
    addr = 32'h0000_0108;
    fetch_word(addr, 0, word, lat, reqs);
    check_value(32'(reqs), 32'd1, "cold miss request count");
    check_value(last_req_addr, {addr[31:4], 4'h0}, "cold miss request address");
    check_value(word, model_word(addr), "cold miss data");
    report_test("cold_miss", start_errors);
  endtask

  task automatic hit_test();
    logic [31:0] addr;
    logic [31:0] word;
    int          lat;
    int          reqs;
    int          start_errors;
    start_errors = errors;
    addr = 32'h0000_010c;
    fetch_word(addr, 0, word, lat, reqs);
    check_value(32'(reqs), 32'd0, "hit request count");
    check_value(32'(lat), 32'd2, "hit latency");
    check_value(word, model_word(addr), "hit data");
    report_test("hit", start_errors);
  endtask

  task automatic backpressure_test();
    logic [31:0] addr;
    logic [31:0] word;
    int          lat;
    int          reqs;
    int          start_errors;
    start_errors = errors;
    addr = 32'h0000_0100;
    fetch_word(addr, 8, word, lat, reqs);
    check_value(32'(reqs), 32'd0, "back-pressure request count");
    check_value(word, model_word(addr), "back-pressure data");
    report_test("backpressure", start_errors);
  endtask

  // Blocks A to E share set 5, then B again and A again
  task automatic replacement_test();
    logic [31:0] seq [7];
    logic        exp_miss [7];
    logic [31:0] word;
    int          lat;
    int          reqs;
    int          start_errors;
    start_errors = errors;
    seq      = '{32'h0000_1054, 32'h0000_2058, 32'h0000_305c, 32'h0000_4050,
                 32'h0000_5054, 32'h0000_2050, 32'h0000_1050};
    exp_miss = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    for (int i = 0; i < 7; i++)
    begin
      fetch_word(seq[i], 0, word, lat, reqs);
      check_value(32'(reqs), 32'(exp_miss[i]), "replacement request count");
      if (exp_miss[i])
        check_value(last_req_addr, {seq[i][31:4], 4'h0}, "replacement request address");
      check_value(word, model_word(seq[i]), "replacement data");
    end
    report_test("replacement", start_errors);
  endtask

  task automatic flush_random_test();
    logic [31:0] addr;
    logic [31:0] word;
    int          lat;
    int          reqs;
    int          start_errors;
    start_errors = errors;
    issue_fetch(32'h0000_0104);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    repeat (6)
    begin
      #(SAMPLE_DELAY);
      check_value(32'(data_v), 32'd0, "valid after flush");
      @(negedge clk);
    end
    for (int i = 0; i < RANDOM_FETCHES; i++)
    begin
      rand_state = next_random(rand_state);
      addr = 32'h0000_8000 + ((rand_state >> 16) & 32'h0000_03fc);
      fetch_word(addr, 0, word, lat, reqs);
      check_value(word, model_word(addr), "random stream data");
    end
    report_test("flush_random", start_errors);
  endtask

  initial
  begin : watchdog
    #(WATCHDOG_TIME);
    $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin : main
    reset      = 1'b1;
    fetch_addr = '0;
    fetch_v    = 1'b0;
    yumi       = 1'b0;
    flush      = 1'b0;
    errors     = 0;
    checks     = 0;
    rand_state = 32'he82a;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    cold_miss_test();
    hit_test();
    backpressure_test();
    replacement_test();
    flush_random_test();
    $display("Summary: %0d tests, %0d checks, %0d errors", TEST_COUNT, checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- sim.f
design/icache_pkg.sv
design/icache_sram.sv
design/icache_lookup.sv
design/icache_lru.sv
design/icache_ctrl.sv
design/icache.sv
tb/icache_assertions.sv
tb/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
